// File: src/scan_pkg.sv
package scan_pkg;

   // Number of independent stream ids tracked by every state table
   localparam int NUM_STREAMS = 64;

   // Width of a stream id, enough to address all streams
   localparam int STREAM_ID_W = $clog2(NUM_STREAMS);

   // Stream identifier carried on the sop beat
   typedef logic [STREAM_ID_W-1:0] stream_id_t;

   // One payload byte of a packet
   typedef logic [7:0] byte_t;

   // One input beat
   // Only the sop beat's stream_id is meaningful
   // sop and eop may both be set for a one-byte packet
   typedef struct packed {
      logic       sop;
      logic       eop;
      stream_id_t stream_id;
      byte_t      data;
   } beat_t;

endpackage : scan_pkg

// File: src/match_pkg.sv
package match_pkg;

   // Number of fixed pattern engines in the scanner
   localparam int NUM_ENGINES = 3;

   // Longest pattern an engine can hold
   localparam int MAX_PAT_LEN = 8;

   // Pattern bytes, index 0 is matched first
   typedef logic [MAX_PAT_LEN-1:0][7:0] pattern_t;

   // Matched prefix length
   // Needs one bit above MAX_PAT_LEN-1 so the advanced value can reach PAT_LEN
   typedef logic [3:0] mstate_t;

   // One bit per engine
   typedef logic [NUM_ENGINES-1:0] engine_mask_t;

   // Packet-match count of one engine
   typedef logic [15:0] count_t;

   // All engine counts side by side, engine 0 in the low bits
   typedef count_t [NUM_ENGINES-1:0] counts_t;

   // Finished-packet report
   typedef struct packed {
      scan_pkg::stream_id_t stream_id;
      engine_mask_t         fired;
   } report_t;

endpackage : match_pkg

// File: src/stream_state_store.sv
module stream_state_store #(
   parameter type state_t = logic,
   parameter int  DEPTH   = scan_pkg::NUM_STREAMS
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  scan_pkg::stream_id_t rd_stream,
   output state_t               rd_state,
   input  logic                 wr_en,
   input  scan_pkg::stream_id_t wr_stream,
   input  state_t               wr_state
);

   // One entry per stream id
   state_t mem [DEPTH];

   // Combinational read
   // Lets the sop beat use the stored state in its own cycle
   assign rd_state = mem[rd_stream];

   // Synchronous write at eop
   // Whole table clears on reset so every stream starts from zero
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         mem[wr_stream] <= wr_state;
      end
   end

endmodule : stream_state_store

// File: src/packet_sequencer.sv
module packet_sequencer #(
   parameter int DEPTH = scan_pkg::NUM_STREAMS
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    beat_vld,
   input  scan_pkg::beat_t         beat,
   input  match_pkg::engine_mask_t enable_mask,
   output logic                    step,
   output logic [7:0]              step_data,
   output logic                    restore,
   output logic                    restore_new,
   output logic                    save,
   output match_pkg::engine_mask_t save_enable,
   output scan_pkg::stream_id_t    cur_stream,
   output logic                    report_vld,
   output match_pkg::report_t      report,
   input  match_pkg::engine_mask_t fired
);

   import scan_pkg::*;

   // Set between the sop beat and the eop beat
   logic       in_pkt;

   // Stream id captured on sop and held for the rest of the packet
   stream_id_t held_id;

   // Beat decode
   logic       sop_beat;

   // Seen-table readout for the current lookup address
   logic       seen_rd;

   assign sop_beat = beat_vld & beat.sop;

   // Lookup and write address
   // The sop beat uses its own id and later beats use the held one
   assign cur_stream = sop_beat ? beat.stream_id : held_id;

   // Beats outside a packet are ignored
   assign step      = beat_vld & (beat.sop | in_pkt);
   assign step_data = beat.data;

   // Restore on sop
   // A stream never saved since reset starts from zero
   assign restore     = sop_beat;
   assign restore_new = sop_beat & ~seen_rd;

   // Save on eop for the engines enabled in this packet
   assign save        = step & beat.eop;
   assign save_enable = save ? enable_mask : '0;

   // Seen-stream table with one bit per stream
   // Marked at every eop whatever the enable mask
   stream_state_store #(
      .state_t (logic),
      .DEPTH   (DEPTH)
   ) u_seen_store (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_stream (cur_stream),
      .rd_state  (seen_rd),
      .wr_en     (save),
      .wr_stream (cur_stream),
      .wr_state  (1'b1)
   );

   // Packet framing
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         in_pkt  <= 1'b0;
         held_id <= '0;
      end
      else
      begin
         if (sop_beat)
         begin
            held_id <= beat.stream_id;
         end
         // eop wins so a single-beat packet leaves in_pkt low
         if (save)
         begin
            in_pkt <= 1'b0;
         end
         else if (sop_beat)
         begin
            in_pkt <= 1'b1;
         end
      end
   end

   // Report strobe one cycle after the eop edge
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         report_vld <= 1'b0;
      end
      else
      begin
         report_vld <= save;
      end
   end

   // Report payload is only meaningful while report_vld is high
   always_ff @(posedge clk)
   begin
      if (save)
      begin
         report.stream_id <= cur_stream;
         report.fired     <= fired;
      end
   end

endmodule : packet_sequencer

// File: src/pattern_matcher.sv
module pattern_matcher #(
   parameter match_pkg::pattern_t PATTERN = '0,
   parameter int                  PAT_LEN = 1
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               step,
   input  logic [7:0]         data,
   input  logic               restore,
   input  logic               restore_new,
   input  match_pkg::mstate_t restored_state,
   output match_pkg::mstate_t next_state,
   output logic               accept
);

   import match_pkg::*;

   // Running prefix length for the packet in progress
   mstate_t state_q;

   // State the current byte is matched against
   mstate_t start_state;

   // Prefix length if the current byte matches
   mstate_t adv;

   // Start from the stored state on sop, zero for a fresh stream
   // Same cycle as the sop byte, no bubble
   always_comb
   begin
      if (restore)
      begin
         start_state = restore_new ? '0 : restored_state;
      end
      else
      begin
         start_state = state_q;
      end
   end

   assign adv = start_state + mstate_t'(1);

   // Match rule
   // Hit extends the prefix, miss restarts at 1 if the byte opens the pattern
   always_comb
   begin
      next_state = start_state;
      accept     = 1'b0;
      if (step)
      begin
         if (data == PATTERN[start_state[2:0]])
         begin
            if (adv == mstate_t'(PAT_LEN))
            begin
               // Full pattern seen
               accept     = 1'b1;
               next_state = '0;
            end
            else
            begin
               next_state = adv;
            end
         end
         else if (data == PATTERN[0])
         begin
            next_state = mstate_t'(1);
         end
         else
         begin
            next_state = '0;
         end
      end
   end

   // Register the new state on every processed byte
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
      end
      else if (step)
      begin
         state_q <= next_state;
      end
   end

endmodule : pattern_matcher

// File: src/match_counter.sv
module match_counter (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              step,
   input  logic              restore,
   input  logic              accept,
   input  logic              save,
   input  logic              enable,
   output match_pkg::count_t count,
   output logic              fired
);

   // Packet has matched at least once so far
   logic flag_q;

   // Flag as seen by the current byte
   // Ignored on sop since it belongs to an earlier packet
   logic flag_cur;

   // Packet matched, counting this cycle's accept
   logic hit;

   assign flag_cur = flag_q & ~restore;
   assign hit      = flag_cur | accept;

   // Fired bit for the report, only for enabled engines
   assign fired = enable & hit;

   // Speculative flag
   // Cleared at eop so the next packet starts clean
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         flag_q <= 1'b0;
      end
      else if (save)
      begin
         flag_q <= 1'b0;
      end
      else if (step)
      begin
         flag_q <= hit;
      end
   end

   // Packet-match count
   // Disabled engines drop the packet's result
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
      end
      else if (save && enable && hit)
      begin
         count <= count + 1'b1;
      end
   end

endmodule : match_counter

// File: src/inspect_top.sv
module inspect_top #(
   parameter int DEPTH = scan_pkg::NUM_STREAMS,
   // Engine 0 "GET ", engine 1 "abc", engine 2 "xyzxyq"
   // Byte 0 of each pattern sits in the low bits
   parameter match_pkg::pattern_t [match_pkg::NUM_ENGINES-1:0] PATTERNS = {
      {8'h00, 8'h00, "q", "y", "x", "z", "y", "x"},
      {8'h00, 8'h00, 8'h00, 8'h00, 8'h00, "c", "b", "a"},
      {8'h00, 8'h00, 8'h00, 8'h00, " ", "T", "E", "G"}
   },
   parameter logic [match_pkg::NUM_ENGINES-1:0][3:0] PAT_LENS = {4'd6, 4'd3, 4'd4}
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    beat_vld,
   input  scan_pkg::beat_t         beat,
   input  match_pkg::engine_mask_t enable_mask,
   output match_pkg::counts_t      counts,
   output logic                    report_vld,
   output match_pkg::report_t      report
);

   import scan_pkg::*;
   import match_pkg::*;

   // Sequencer controls broadcast to every engine
   logic         step;
   logic [7:0]   step_data;
   logic         restore;
   logic         restore_new;
   logic         save;
   engine_mask_t save_enable;
   stream_id_t   cur_stream;

   // Per-engine fired bits gathered for the report
   engine_mask_t fired;

   packet_sequencer #(
      .DEPTH (DEPTH)
   ) u_sequencer (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat_vld    (beat_vld),
      .beat        (beat),
      .enable_mask (enable_mask),
      .step        (step),
      .step_data   (step_data),
      .restore     (restore),
      .restore_new (restore_new),
      .save        (save),
      .save_enable (save_enable),
      .cur_stream  (cur_stream),
      .report_vld  (report_vld),
      .report      (report),
      .fired       (fired)
   );

   for (genvar k = 0; k < NUM_ENGINES; k++)
   begin : g_engine
      mstate_t restored_state;
      mstate_t next_state;
      logic    accept;

      // Per-stream match state of this engine
      stream_state_store #(
         .state_t (mstate_t),
         .DEPTH   (DEPTH)
      ) u_state_store (
         .clk       (clk),
         .rst_n     (rst_n),
         .rd_stream (cur_stream),
         .rd_state  (restored_state),
         .wr_en     (save & save_enable[k]),
         .wr_stream (cur_stream),
         .wr_state  (next_state)
      );

      pattern_matcher #(
         .PATTERN (PATTERNS[k]),
         .PAT_LEN (int'(PAT_LENS[k]))
      ) u_matcher (
         .clk            (clk),
         .rst_n          (rst_n),
         .step           (step),
         .data           (step_data),
         .restore        (restore),
         .restore_new    (restore_new),
         .restored_state (restored_state),
         .next_state     (next_state),
         .accept         (accept)
      );

      match_counter u_counter (
         .clk     (clk),
         .rst_n   (rst_n),
         .step    (step),
         .restore (restore),
         .accept  (accept),
         .save    (save),
         .enable  (save_enable[k]),
         .count   (counts[k]),
         .fired   (fired[k])
      );
   end

endmodule : inspect_top

// File: bench/clock_gen.sv
module clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free-running clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   // Synchronous reset, released just after an edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule : clock_gen

// File: bench/inspect_tb.sv
module inspect_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import scan_pkg::*;
   import match_pkg::*;

   localparam int REPORT_TIMEOUT = 50;
   localparam int RESET_TIMEOUT  = 20;
   localparam int NUM_RANDOM     = 400;

   logic         clk;
   logic         rst_n;
   logic         beat_vld;
   beat_t        beat;
   engine_mask_t enable_mask;
   counts_t      counts;
   logic         report_vld;
   report_t      report;

   // Patterns as the DUT was built with them
   pattern_t pats [NUM_ENGINES];
   int       lens [NUM_ENGINES];

   // Reference model state
   mstate_t  model_state [NUM_ENGINES][NUM_STREAMS];
   logic     model_seen [NUM_STREAMS];
   counts_t  exp_counts;

   // LCG state and the bytes of the packet being built
   logic [31:0] rng_state;
   byte_t       pkt_bytes [$];

   clock_gen #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (4)
   ) u_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   inspect_top inspect_top_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat_vld    (beat_vld),
      .beat        (beat),
      .enable_mask (enable_mask),
      .counts      (counts),
      .report_vld  (report_vld),
      .report      (report)
   );

   function automatic int unsigned rand_below(int unsigned n);
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      // Upper bits are the better ones in an LCG
      return (rng_state >> 8) % n;
   endfunction

   // Biased toward pattern letters so matches are common
   function automatic byte_t rand_byte();
      string alpha = "GET abcxyzq";
      if (rand_below(4) != 0)
      begin
         return alpha[rand_below(alpha.len())];
      end
      return byte_t'(rand_below(256));
   endfunction

   // A few favoured ids force state reuse across packets
   function automatic stream_id_t pick_stream();
      case (rand_below(6))
         0: return stream_id_t'(2);
         1: return stream_id_t'(5);
         2: return stream_id_t'(17);
         3: return stream_id_t'(40);
         default: return stream_id_t'(rand_below(NUM_STREAMS));
      endcase
   endfunction

   function automatic engine_mask_t pick_enable();
      if (rand_below(3) != 0)
      begin
         return '1;
      end
      return engine_mask_t'(rand_below(8));
   endfunction

   // One byte of the restart match rule for engine k
   function automatic mstate_t match_step(int k, mstate_t s, byte_t c, output logic acc);
      acc = 1'b0;
      if (c == pats[k][s])
      begin
         if (int'(s) + 1 == lens[k])
         begin
            acc = 1'b1;
            return '0;
         end
         return s + 1'b1;
      end
      if (c == pats[k][0])
      begin
         return mstate_t'(1);
      end
      return '0;
   endfunction

   task automatic fail_run(string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_report(string name, report_t exp, report_t act);
      if (act !== exp)
      begin
         fail_run($sformatf(
            "MISMATCH %s report expected stream %0d fired %b actual stream %0d fired %b",
            name, exp.stream_id, exp.fired, act.stream_id, act.fired));
      end
   endtask

   task automatic compare_counts(string name, counts_t exp, counts_t act);
      if (act !== exp)
      begin
         fail_run($sformatf("MISMATCH %s counts expected %h actual %h", name, exp, act));
      end
   endtask

   // Idle cycle with junk on the bus
   // report_vld must stay low
   task automatic idle_cycle();
      @(posedge clk);
      #1;
      beat_vld = 1'b0;
      beat     = beat_t'(rand_below(65536));
      if (report_vld !== 1'b0)
      begin
         fail_run("report_vld was high in a cycle where no packet had just ended");
      end
   endtask

   task automatic set_bytes(string s);
      pkt_bytes.delete();
      for (int i = 0; i < s.len(); i++)
      begin
         pkt_bytes.push_back(s[i]);
      end
   endtask

   // Mix of loose bytes and pattern heads and tails
   task automatic build_random_packet(int len);
      int k;
      int cut;
      pkt_bytes.delete();
      while (pkt_bytes.size() < len)
      begin
         if (rand_below(3) == 0)
         begin
            k   = rand_below(NUM_ENGINES);
            cut = rand_below(lens[k]);
            if (rand_below(2) == 0)
            begin
               // Head only
               // The tail may come in the stream's next packet
               for (int i = 0; i <= cut; i++)
               begin
                  pkt_bytes.push_back(pats[k][i]);
               end
            end
            else
            begin
               for (int i = cut; i < lens[k]; i++)
               begin
                  pkt_bytes.push_back(pats[k][i]);
               end
            end
         end
         else
         begin
            pkt_bytes.push_back(rand_byte());
         end
      end
      while (pkt_bytes.size() > len)
      begin
         void'(pkt_bytes.pop_back());
      end
   endtask

   // Model the packet, drive it, then check the report and counts
   task automatic send_packet(string name, stream_id_t sid, engine_mask_t en, int max_gap);
      report_t exp_rep;
      mstate_t s;
      logic    acc;
      logic    hit;
      beat_t   b;
      int      n;
      int      waited;
      exp_rep.stream_id = sid;
      exp_rep.fired     = '0;
      for (int k = 0; k < NUM_ENGINES; k++)
      begin
         s   = model_seen[sid] ? model_state[k][sid] : '0;
         hit = 1'b0;
         foreach (pkt_bytes[i])
         begin
            s   = match_step(k, s, pkt_bytes[i], acc);
            hit = hit | acc;
         end
         // Disabled engine keeps its old state and count
         if (en[k])
         begin
            model_state[k][sid] = s;
            exp_rep.fired[k]    = hit;
            if (hit)
            begin
               exp_counts[k] = exp_counts[k] + 1'b1;
            end
         end
      end
      model_seen[sid] = 1'b1;

      n = pkt_bytes.size();
      for (int i = 0; i < n; i++)
      begin
         repeat (rand_below(max_gap + 1)) idle_cycle();
         @(posedge clk);
         #1;
         b.sop       = (i == 0);
         b.eop       = (i == n - 1);
         // Only the sop id counts and the rest carry junk
         b.stream_id = (i == 0) ? sid : stream_id_t'(rand_below(NUM_STREAMS));
         b.data      = pkt_bytes[i];
         beat        = b;
         beat_vld    = 1'b1;
         enable_mask = (i == n - 1) ? en : engine_mask_t'(rand_below(8));
      end
      @(posedge clk);
      #1;
      beat_vld = 1'b0;

      waited = 0;
      while (report_vld !== 1'b1)
      begin
         if (waited >= REPORT_TIMEOUT)
         begin
            fail_run($sformatf("no report_vld within %0d cycles after %s",
                               REPORT_TIMEOUT, name));
         end
         @(posedge clk);
         #1;
         waited++;
      end
      // The report belongs in the cycle right after the eop edge
      if (waited != 0)
      begin
         fail_run($sformatf("report_vld for %s came %0d cycles late", name, waited));
      end
      compare_report(name, exp_rep, report);
      compare_counts(name, exp_counts, counts);
   endtask

   initial
   begin
      int waited;
      beat_vld    = 1'b0;
      beat        = '0;
      enable_mask = '0;
      rng_state   = 32'd8700;
      exp_counts  = '0;
      foreach (model_seen[i])
      begin
         model_seen[i] = 1'b0;
      end
      for (int k = 0; k < NUM_ENGINES; k++)
      begin
         pats[k] = inspect_top_inst.PATTERNS[k];
         lens[k] = int'(inspect_top_inst.PAT_LENS[k]);
         for (int s = 0; s < NUM_STREAMS; s++)
         begin
            model_state[k][s] = '0;
         end
      end

      waited = 0;
      while (rst_n !== 1'b1)
      begin
         if (waited >= RESET_TIMEOUT)
         begin
            fail_run("reset was never released");
         end
         @(posedge clk);
         waited++;
      end
      #1;

      // Quiet bus after reset
      compare_counts("after reset", '0, counts);
      repeat (10) idle_cycle();

      set_bytes("GET abc xyzxyq");
      send_packet("whole patterns in one packet", stream_id_t'(1), '1, 0);

      // xyzxyq split over two packets of stream 5 with stream 9 between
      set_bytes("xyz");
      send_packet("split pattern head", stream_id_t'(5), '1, 1);
      set_bytes("abc");
      send_packet("interleaved stream", stream_id_t'(9), '1, 1);
      set_bytes("xyq");
      send_packet("split pattern tail", stream_id_t'(5), '1, 1);

      // Engine 0 off for the middle packet so its saved prefix survives
      set_bytes("GE");
      send_packet("prefix saved", stream_id_t'(7), '1, 0);
      set_bytes("T ");
      send_packet("engine 0 disabled", stream_id_t'(7), 3'b110, 0);
      set_bytes("T ");
      send_packet("engine 0 enabled again", stream_id_t'(7), '1, 0);

      // Single-beat packets building abc one byte at a time
      // A first packet of a new stream cuts in after the a and starts from zero
      set_bytes("a");
      send_packet("single beat a", stream_id_t'(12), '1, 0);
      set_bytes("bc");
      send_packet("new stream", stream_id_t'(33), '1, 0);
      set_bytes("b");
      send_packet("single beat b", stream_id_t'(12), '1, 0);
      set_bytes("c");
      send_packet("single beat c", stream_id_t'(12), '1, 0);

      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         build_random_packet(1 + int'(rand_below(12)));
         send_packet($sformatf("random packet %0d", n), pick_stream(), pick_enable(), 2);
      end

      repeat (5) idle_cycle();
      compare_counts("final counts", exp_counts, counts);
      $display("all tests passed");
      $finish;
   end

endmodule : inspect_tb

// File: verilog.f
src/scan_pkg.sv
src/match_pkg.sv
src/stream_state_store.sv
src/packet_sequencer.sv
src/pattern_matcher.sv
src/match_counter.sv
src/inspect_top.sv
bench/clock_gen.sv
bench/inspect_tb.sv
